/* test/data_mem_tests.txt */
# name we size address wdata exp_err exp_rdata
# size is the funct3 code, all numbers hex, stores expect rdata 0
sw_word 1 2 00000100 deadbeef 0 00000000
lw_word 0 2 00000100 00000000 0 deadbeef
sb_lane0 1 0 00000200 00000011 0 00000000
sb_lane1 1 0 00000201 00000022 0 00000000
sb_lane2 1 0 00000202 00000033 0 00000000
sb_lane3 1 0 00000203 00000044 0 00000000
lw_bytes 0 2 00000200 00000000 0 44332211
sb_mid 1 4 00000201 0000005a 0 00000000
lw_merged 0 2 00000200 00000000 0 44335a11
sw_signs 1 2 00000300 80f07f9c 0 00000000
lb_neg 0 0 00000300 00000000 0 ffffff9c
lbu_neg 0 4 00000300 00000000 0 0000009c
lh_neg 0 1 00000302 00000000 0 ffff80f0
lhu_neg 0 5 00000302 00000000 0 000080f0
sh_odd 1 1 00000301 00001234 1 00000000
sw_unaligned 1 2 00000302 ffffffff 1 00000000
lw_unaligned 0 2 00000301 00000000 1 00000000
lw_unchanged 0 2 00000300 00000000 0 80f07f9c
sh_low 1 1 00000400 0000beef 0 00000000
lhu_low 0 5 00000400 00000000 0 0000beef

/* compile.f */
verilog/lsu_pkg.sv
verilog/lsu_stage_if.sv
verilog/store_align.sv
verilog/data_memory.sv
verilog/load_extend.sv
verilog/data_mem_top.sv
test/tb_clock.sv
test/data_mem_properties.sv
test/data_mem_tb.sv

/* Bender.yml */
package:
  name: data_mem

sources:
  - verilog/lsu_pkg.sv
  - verilog/lsu_stage_if.sv
  - verilog/store_align.sv
  - verilog/data_memory.sv
  - verilog/load_extend.sv
  - verilog/data_mem_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/data_mem_properties.sv
      - test/data_mem_tb.sv

/* test/data_mem_tb.sv */
//--------------------------------------------------------------------------
// Testbench for data_mem_top: reads test records, drives Wishbone
// requests, checks ack, err, latency and read data, prints a summary
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module data_mem_tb;

	logic           clk;
	logic           arst_n;
	logic           wb_cyc;
	logic           wb_stb;
	logic           wb_we;
	logic [31:0]    wb_adr;
	logic [31:0]    wb_dat_w;
	lsu_pkg::size_t wb_size;
	logic [31:0]    wb_dat_r;
	logic           wb_ack;
	logic           wb_err;

	// One entry per test record
	string       t_name[$];
	logic        t_we[$];
	logic [2:0]  t_size[$];
	logic [31:0] t_adr[$];
	logic [31:0] t_wdata[$];
	logic        t_err[$];
	logic [31:0] t_rdata[$];

	int passed = 0;
	int failed = 0;
	int resp_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	tb_clock clock_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	data_mem_top #(
		.ADDR_BITS (10)
	) data_mem_top_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_size  (wb_size),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.wb_err   (wb_err)
	);

	// Lines that do not parse as seven fields are skipped (comments)
	task automatic load_tests(output bit ok);
		int          fd;
		int          n;
		string       line;
		string       name;
		logic [31:0] we_v, size_v, adr_v, wdata_v, err_v, rdata_v;
		ok = 1'b0;
		fd = $fopen("test/data_mem_tests.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				n = $sscanf(line, "%s %h %h %h %h %h %h", name, we_v, size_v, adr_v,
					wdata_v, err_v, rdata_v);
				if (n == 7) begin
					t_name.push_back(name);
					t_we.push_back(we_v[0]);
					t_size.push_back(size_v[2:0]);
					t_adr.push_back(adr_v);
					t_wdata.push_back(wdata_v);
					t_err.push_back(err_v[0]);
					t_rdata.push_back(rdata_v);
				end
			end
			$fclose(fd);
		end
	endtask

	// One request, held until the response, then one idle cycle
	task automatic run_test(input int i);
		int          cycles;
		bit          done;
		bit          ok;
		logic        ack_v;
		logic        err_v;
		logic [31:0] data_v;
		cycles = 0;
		done = 1'b0;
		ok = 1'b1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = t_we[i];
		wb_adr = t_adr[i];
		wb_dat_w = t_wdata[i];
		wb_size = lsu_pkg::size_t'(t_size[i]);
		// Poll just after each edge, outputs settled there
		while (!done && cycles < 8) begin
			@(posedge clk);
			#1;
			cycles++;
			done = wb_ack || wb_err;
		end
		ack_v = wb_ack;
		err_v = wb_err;
		data_v = wb_dat_r;
		assert (done) else begin
			$display("Test %s got neither ack nor err within %0d cycles", t_name[i], cycles);
			ok = 1'b0;
		end
		assert (cycles == 3) else begin
			$display("FAIL %s: latency expected 3 actual %0d", t_name[i], cycles);
			ok = 1'b0;
		end
		assert (ack_v == !t_err[i] && err_v == t_err[i]) else begin
			$display("FAIL %s: ack,err expected %b,%b actual %b,%b", t_name[i],
				!t_err[i], t_err[i], ack_v, err_v);
			ok = 1'b0;
		end
		// Stores expect zero, error responses carry no data
		if (!t_err[i]) begin
			assert (data_v === t_rdata[i]) else begin
				$display("FAIL %s: data expected %h actual %h", t_name[i], t_rdata[i], data_v);
				ok = 1'b0;
			end
		end
		if (ok) begin
			passed++;
			$display("ok   %s", t_name[i]);
		end else begin
			failed++;
		end
		// Master sees the response on the next edge and drops stb
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(posedge clk);
		#1;
	endtask

	// Every pulse counted once, sampled mid cycle
	always @(negedge clk) begin
		if (wb_ack || wb_err)
			resp_count++;
	end

	// Cycle limit watchdog
	initial begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		bit loaded;
		bit bad_run;
		bad_run = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_size = lsu_pkg::SZ_W;
		load_tests(loaded);
		cycle_limit = 6 * t_name.size() + 20;
		assert (loaded && t_name.size() > 0) else begin
			$display("Could not read any test record from test/data_mem_tests.txt");
			bad_run = 1'b1;
		end
		@(posedge arst_n);
		@(posedge clk);
		#1;
		for (int i = 0; i < t_name.size(); i++)
			run_test(i);
		assert (resp_count == t_name.size()) else begin
			$display("Expected %0d responses in total but saw %0d", t_name.size(), resp_count);
			bad_run = 1'b1;
		end
		$display("Tests: %0d run, %0d passed, %0d failed", t_name.size(), passed, failed);
		if (failed == 0 && !bad_run)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* test/data_mem_properties.sv */
//--------------------------------------------------------------------------
// Concurrent checks on the Wishbone handshake of data_mem_top
// Attached to every data_mem_top instance through bind
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module data_mem_properties (
	input logic clk,
	input logic arst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic wb_err
);

	logic resp;

	assign resp = wb_ack || wb_err;

	// Never both responses at once
	ack_err_exclusive: assert property (
		@(posedge clk) disable iff (!arst_n) !(wb_ack && wb_err))
		else $error("wb_ack and wb_err high in the same cycle");

	// Single cycle pulse
	resp_one_cycle: assert property (
		@(posedge clk) disable iff (!arst_n) resp |=> !resp)
		else $error("Response held for more than one cycle");

	// New request answered on the third edge, silent before
	resp_latency: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(wb_cyc && wb_stb) |-> ##1 !resp [*2] ##1 resp)
		else $error("Response did not follow the request after 3 cycles");

endmodule

bind data_mem_top data_mem_properties data_mem_properties_inst (
	.clk    (clk),
	.arst_n (arst_n),
	.wb_cyc (wb_cyc),
	.wb_stb (wb_stb),
	.wb_ack (wb_ack),
	.wb_err (wb_err)
);

/* test/tb_clock.sv */
//--------------------------------------------------------------------------
// Testbench clock, 100 ns period, and active low reset
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module tb_clock #(
	parameter int HALF_PERIOD  = 50,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Released just after the last reset edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 arst_n = 1'b1;
	end

endmodule

/* verilog/data_mem_top.sv */
//--------------------------------------------------------------------------
// Data memory with Wishbone classic slave front end
// Three stages: align, memory, extend
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module data_mem_top #(
	parameter int ADDR_BITS = 10
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            wb_cyc,
	input  logic                            wb_stb,
	input  logic                            wb_we,
	input  logic [lsu_pkg::DATA_WIDTH-1:0]  wb_adr,
	input  logic [lsu_pkg::DATA_WIDTH-1:0]  wb_dat_w,
	input  lsu_pkg::size_t                  wb_size,
	output logic [lsu_pkg::DATA_WIDTH-1:0]  wb_dat_r,
	output logic                            wb_ack,
	output logic                            wb_err
);

	// Response seen by the align stage
	logic resp_done;

	// Align to memory, and memory to extend
	lsu_stage_if #(.ADDR_BITS(ADDR_BITS)) align_to_mem ();
	lsu_stage_if #(.ADDR_BITS(ADDR_BITS)) mem_to_ext ();

	// Request capture at edge 0
	store_align #(
		.ADDR_BITS (ADDR_BITS)
	) store_align_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_size   (wb_size),
		.resp_done (resp_done),
		.out       (align_to_mem.src)
	);

	// RAM access at edge 1
	data_memory #(
		.ADDR_BITS (ADDR_BITS)
	) data_memory_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.in     (align_to_mem.dst),
		.out    (mem_to_ext.src)
	);

	// Response registered at edge 2
	load_extend load_extend_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.in        (mem_to_ext.dst),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.wb_err    (wb_err),
		.resp_done (resp_done)
	);

endmodule

/* verilog/load_extend.sv */
//--------------------------------------------------------------------------
// Extend stage: load lane select, sign or zero extension,
// Wishbone ack and err generation
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module load_extend (
	input  logic                            clk,
	input  logic                            arst_n,
	lsu_stage_if.dst                        in,
	output logic [lsu_pkg::DATA_WIDTH-1:0]  wb_dat_r,
	output logic                            wb_ack,
	output logic                            wb_err,
	output logic                            resp_done
);

	logic [7:0]                     byte_sel;
	logic [15:0]                    half_sel;
	logic [lsu_pkg::DATA_WIDTH-1:0] load_data;

	// Byte at offset, halfword from the upper or lower pair of lanes
	assign byte_sel = in.rdata.lane[in.offset];
	assign half_sel = {in.rdata.lane[{in.offset[1], 1'b1}], in.rdata.lane[{in.offset[1], 1'b0}]};

	always_comb begin
		case (in.size)
			lsu_pkg::SZ_B:  load_data = {{24{byte_sel[7]}}, byte_sel};
			lsu_pkg::SZ_BU: load_data = {24'b0, byte_sel};
			lsu_pkg::SZ_H:  load_data = {{16{half_sel[15]}}, half_sel};
			lsu_pkg::SZ_HU: load_data = {16'b0, half_sel};
			lsu_pkg::SZ_W:  load_data = in.rdata.word;
			default:        load_data = '0;
		endcase
	end

	// One-cycle response per valid, err wins over ack
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack <= 1'b0;
			wb_err <= 1'b0;
		end else begin
			wb_ack <= in.valid && !in.err;
			wb_err <= in.valid && in.err;
		end
	end

	// Stores and errors return zero
	always_ff @(posedge clk) begin
		if (in.valid)
			wb_dat_r <= (in.we || in.err) ? '0 : load_data;
	end

	// Releases the align stage for the next request
	assign resp_done = wb_ack || wb_err;

endmodule

/* verilog/data_memory.sv */
//--------------------------------------------------------------------------
// Memory stage: byte-lane-writable RAM with a registered read,
// forwards the access attributes one cycle later
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module data_memory #(
	parameter int ADDR_BITS = 10
) (
	input  logic      clk,
	input  logic      arst_n,
	lsu_stage_if.dst  in,
	lsu_stage_if.src  out
);

	// 2^ADDR_BITS words, contents undefined after power up
	lsu_pkg::mem_word_t mem [2**ADDR_BITS];

	// Lane writes, be is all zero for loads and misaligned stores
	always_ff @(posedge clk) begin
		if (in.valid && in.we) begin
			for (int i = 0; i < lsu_pkg::NUM_LANES; i++) begin
				if (in.be[i])
					mem[in.index].lane[i] <= in.wdata.lane[i];
			end
		end
	end

	// Registered read of the whole word, extend stage picks the lanes
	always_ff @(posedge clk) begin
		if (in.valid) begin
			out.we <= in.we;
			out.size <= in.size;
			out.offset <= in.offset;
			out.err <= in.err;
			if (!in.we)
				out.rdata <= mem[in.index];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			out.valid <= 1'b0;
		else
			out.valid <= in.valid;
	end

	// Address and store fields end here
	assign out.index = '0;
	assign out.be = '0;
	assign out.wdata = '0;

endmodule

/* verilog/store_align.sv */
//--------------------------------------------------------------------------
// Align stage: Wishbone request capture, alignment check,
// byte-enable mask and store-data lane placement
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module store_align #(
	parameter int ADDR_BITS = 10
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            wb_cyc,
	input  logic                            wb_stb,
	input  logic                            wb_we,
	input  logic [lsu_pkg::DATA_WIDTH-1:0]  wb_adr,
	input  logic [lsu_pkg::DATA_WIDTH-1:0]  wb_dat_w,
	input  lsu_pkg::size_t                  wb_size,
	input  logic                            resp_done,
	lsu_stage_if.src                        out
);

	logic                            busy;
	logic                            accept;
	logic                            misaligned;
	logic [lsu_pkg::OFFSET_BITS-1:0] offset;
	lsu_pkg::be_t                    be_mask;

	// Master holds the request until ack, so busy blocks a second capture
	assign accept = wb_cyc && wb_stb && !busy;

	// Byte position inside the word
	assign offset = wb_adr[lsu_pkg::OFFSET_BITS-1:0];

	// Lane mask and alignment rule per size code
	always_comb begin
		misaligned = 1'b0;
		be_mask = '0;
		case (wb_size)
			lsu_pkg::SZ_B, lsu_pkg::SZ_BU: begin
				be_mask = lsu_pkg::be_t'(1) << offset;
			end
			lsu_pkg::SZ_H, lsu_pkg::SZ_HU: begin
				// Halfword must sit on an even address
				misaligned = offset[0];
				be_mask = lsu_pkg::be_t'(3) << offset;
			end
			lsu_pkg::SZ_W: begin
				misaligned = |offset;
				be_mask = '1;
			end
			// Unknown funct3, refuse it
			default: misaligned = 1'b1;
		endcase
	end

	// Valid pulse and busy flag
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			out.valid <= 1'b0;
		end else begin
			out.valid <= accept;
			if (accept)
				busy <= 1'b1;
			else if (resp_done)
				busy <= 1'b0;
		end
	end

	// Request fields, loaded once per accepted access
	always_ff @(posedge clk) begin
		if (accept) begin
			out.we <= wb_we;
			out.index <= wb_adr[ADDR_BITS+lsu_pkg::OFFSET_BITS-1:lsu_pkg::OFFSET_BITS];
			// No lane is written by a load or a misaligned store
			out.be <= (wb_we && !misaligned) ? be_mask : '0;
			// Move store data up to the addressed lane
			out.wdata.word <= wb_dat_w << {offset, 3'b000};
			out.size <= wb_size;
			out.offset <= offset;
			out.err <= misaligned;
		end
	end

	// Nothing read yet at this stage
	assign out.rdata = '0;

endmodule

/* verilog/lsu_stage_if.sv */
//--------------------------------------------------------------------------
// Stage-to-stage link of the load/store pipeline
// Carries one access per valid pulse, src and dst modports
//--------------------------------------------------------------------------

`timescale 1ns/10ps

interface lsu_stage_if #(
	parameter int ADDR_BITS = 10
);

	// One-cycle pulse, no back-pressure
	logic valid;
	logic we;
	// Word index into the RAM
	logic [ADDR_BITS-1:0] index;
	lsu_pkg::be_t be;
	// Store data already placed in its lanes
	lsu_pkg::mem_word_t wdata;
	// Whole word read from the RAM
	lsu_pkg::mem_word_t rdata;
	lsu_pkg::size_t size;
	logic [lsu_pkg::OFFSET_BITS-1:0] offset;
	// Misaligned access, answered with wb_err
	logic err;

	modport src (output valid, we, index, be, wdata, rdata, size, offset, err);
	modport dst (input valid, we, index, be, wdata, rdata, size, offset, err);

endinterface

/* verilog/lsu_pkg.sv */
//--------------------------------------------------------------------------
// Shared widths, access size codes and word types for the load/store path
// Size codes follow the RISC-V funct3 field of loads and stores
//--------------------------------------------------------------------------

package lsu_pkg;

	// Bus and memory word width
	parameter int DATA_WIDTH = 32;

	// Byte lanes per word
	parameter int NUM_LANES = DATA_WIDTH / 8;

	// Byte offset bits inside one word
	parameter int OFFSET_BITS = $clog2(NUM_LANES);

	// Access size, same encoding as funct3
	// Bit 2 set means zero extension on loads
	typedef enum logic [2:0] {
		SZ_B  = 3'b000,
		SZ_H  = 3'b001,
		SZ_W  = 3'b010,
		SZ_BU = 3'b100,
		SZ_HU = 3'b101
	} size_t;

	// One enable bit per byte lane
	typedef logic [NUM_LANES-1:0] be_t;

	// Memory word, seen whole or as byte lanes
	// Lane 0 is the least significant byte (little endian)
	typedef union packed {
		logic [DATA_WIDTH-1:0]     word;
		logic [NUM_LANES-1:0][7:0] lane;
	} mem_word_t;

endpackage
